//--- Bender.yml
package:
  name: core_top

export_include_dirs:
  - include

sources:
  - logic/core_pkg.sv
  - logic/wb_bus.sv
  - logic/ifetch.sv
  - logic/ins_queue.sv
  - logic/execute.sv
  - logic/buscontrol.sv
  - logic/ram.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - test/tb_core_top.sv

//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Word address width of the shared RAM.
`define CORE_ADR_W 10

`define CORE_DAT_W 32

// Instruction queue entries, a power of two of 2 or more.
`define CORE_INSQ_DEPTH 4

`endif

//--- logic/buscontrol.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module buscontrol (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   run_i,
  input  logic                   load_we_i,
  input  logic [`CORE_ADR_W-1:0] load_adr_i,
  input  logic [`CORE_DAT_W-1:0] load_dat_i,
  wb_bus.slave                   ins_bus,
  wb_bus.slave                   dat_bus,
  wb_bus.master                  mem_bus
);
  logic busy;    // Granted access waits for ack.
  logic gnt_dat;
  logic ins_wait;
  logic dat_wait;
  logic ins_req;
  logic dat_req;
  logic start;
  logic use_dat;

  // A strobe that finds the RAM busy is held until granted.
  assign ins_req = (ins_bus.cyc && ins_bus.stb) || ins_wait;
  assign dat_req = (dat_bus.cyc && dat_bus.stb) || dat_wait;
  assign start   = run_i && !busy && (ins_req || dat_req);
  assign use_dat = busy ? gnt_dat : dat_req; // Data bus has priority.

  assign mem_bus.cyc   = run_i ? (busy || start) : load_we_i;
  assign mem_bus.stb   = run_i ? start : load_we_i;
  assign mem_bus.we    = run_i ? (use_dat ? dat_bus.we : ins_bus.we) : 1'b1;
  assign mem_bus.adr   = run_i ? (use_dat ? dat_bus.adr : ins_bus.adr) : load_adr_i;
  assign mem_bus.dat_w = run_i ? (use_dat ? dat_bus.dat_w : ins_bus.dat_w) : load_dat_i;

  assign ins_bus.dat_r = mem_bus.dat_r;
  assign dat_bus.dat_r = mem_bus.dat_r;
  assign ins_bus.ack   = mem_bus.ack && busy && !gnt_dat;
  assign dat_bus.ack   = mem_bus.ack && busy && gnt_dat;

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      busy     <= 1'b0;
      gnt_dat  <= 1'b0;
      ins_wait <= 1'b0;
      dat_wait <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        busy    <= 1'b1;
        gnt_dat <= dat_req;
      end
      else if (mem_bus.ack)
        busy <= 1'b0;
      ins_wait <= ins_req && !(start && !dat_req);
      dat_wait <= dat_req && !start;
    end
endmodule

//--- logic/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef enum logic [3:0] {
    NOP   = 4'h0,
    LDI   = 4'h1,
    ADDI  = 4'h2,
    LOAD  = 4'h3,
    STORE = 4'h4,
    HALT  = 4'hf
  } opcode_e;

  typedef enum logic [1:0] {EXE_RUN, EXE_MEM, EXE_HALTED} exe_state_e;

  function automatic opcode_e op_of(input logic [`CORE_DAT_W-1:0] ins);
    return opcode_e'(ins[31:28]);
  endfunction

  // Immediate or word address, zero-extended.
  function automatic logic [`CORE_DAT_W-1:0] imm_of(input logic [`CORE_DAT_W-1:0] ins);
    return {{(`CORE_DAT_W-16){1'b0}}, ins[15:0]};
  endfunction

endpackage

//--- logic/core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   run_i,
  input  logic                   load_we_i,
  input  logic [`CORE_ADR_W-1:0] load_adr_i,
  input  logic [`CORE_DAT_W-1:0] load_dat_i,
  output logic [`CORE_DAT_W-1:0] acc_o,
  output logic                   st_valid_o,
  output logic [`CORE_ADR_W-1:0] st_adr_o,
  output logic [`CORE_DAT_W-1:0] st_dat_o,
  output logic                   halted_o
);
  logic                   push;
  logic [`CORE_DAT_W-1:0] push_data;
  logic                   full;
  logic                   almost_full;
  logic                   empty;
  logic [`CORE_DAT_W-1:0] head;
  logic                   pop;

  wb_bus ins_bus();
  wb_bus dat_bus();
  wb_bus mem_bus();

  ifetch u_ifetch (.clk_i, .arst_n_i, .run_i, .bus(ins_bus), .push_o(push),
                   .push_data_o(push_data), .full_i(full), .almost_full_i(almost_full));

  ins_queue u_ins_queue (.clk_i, .arst_n_i, .push_i(push), .push_data_i(push_data),
                         .pop_i(pop), .head_o(head), .empty_o(empty), .full_o(full),
                         .almost_full_o(almost_full));

  execute u_execute (.clk_i, .arst_n_i, .run_i, .empty_i(empty), .head_i(head),
                     .pop_o(pop), .bus(dat_bus), .acc_o, .st_valid_o, .st_adr_o,
                     .st_dat_o, .halted_o);

  buscontrol u_buscontrol (.clk_i, .arst_n_i, .run_i, .load_we_i, .load_adr_i,
                           .load_dat_i, .ins_bus(ins_bus), .dat_bus(dat_bus),
                           .mem_bus(mem_bus));

  ram u_ram (.clk_i, .arst_n_i, .bus(mem_bus));
endmodule

//--- logic/execute.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   run_i,
  input  logic                   empty_i,
  input  logic [`CORE_DAT_W-1:0] head_i,
  output logic                   pop_o,
  wb_bus.master                  bus,
  output logic [`CORE_DAT_W-1:0] acc_o,
  output logic                   st_valid_o,
  output logic [`CORE_ADR_W-1:0] st_adr_o,
  output logic [`CORE_DAT_W-1:0] st_dat_o,
  output logic                   halted_o
);
  import core_pkg::*;

  exe_state_e             state;
  opcode_e                op;
  logic [`CORE_DAT_W-1:0] imm;
  logic [`CORE_DAT_W-1:0] acc;
  logic                   go;
  logic                   mem_op;
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`CORE_ADR_W-1:0] adr;
  logic [`CORE_DAT_W-1:0] wdat;

  assign op     = op_of(head_i);
  assign imm    = imm_of(head_i);
  assign go     = (state == EXE_RUN) && run_i && !empty_i;
  assign mem_op = (op == LOAD) || (op == STORE);

  // Loads and stores leave the queue in their ack cycle.
  assign pop_o      = (go && !mem_op) || ((state == EXE_MEM) && bus.ack);
  assign st_valid_o = (state == EXE_MEM) && bus.ack && we;
  assign st_adr_o   = adr;
  assign st_dat_o   = wdat;
  assign halted_o   = (state == EXE_HALTED);
  assign acc_o      = acc;

  assign bus.cyc   = cyc;
  assign bus.stb   = stb;
  assign bus.we    = we;
  assign bus.adr   = adr;
  assign bus.dat_w = wdat;

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      state <= EXE_RUN;
      acc   <= '0;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
    end
    else
    begin
      stb <= 1'b0;
      case (state)
        EXE_RUN:
          if (go)
          begin
            case (op)
              LDI:  acc <= imm;
              ADDI: acc <= acc + imm; // Wraps modulo 2**32.
              LOAD, STORE:
              begin
                cyc   <= 1'b1;
                stb   <= 1'b1;
                we    <= (op == STORE);
                state <= EXE_MEM;
              end
              HALT:    state <= EXE_HALTED;
              default: ; // Unknown opcodes run as NOP.
            endcase
          end
        EXE_MEM:
          if (bus.ack)
          begin
            cyc   <= 1'b0;
            state <= EXE_RUN;
            if (!we)
              acc <= bus.dat_r;
          end
        default: ;
      endcase
    end

  always_ff @(posedge clk_i)
    if (go && mem_op)
    begin
      adr  <= imm[`CORE_ADR_W-1:0];
      wdat <= acc;
    end
endmodule

//--- logic/ifetch.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module ifetch (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   run_i,
  wb_bus.master                  bus,
  output logic                   push_o,
  output logic [`CORE_DAT_W-1:0] push_data_o,
  input  logic                   full_i,
  input  logic                   almost_full_i
);
  logic [`CORE_ADR_W-1:0] pc;
  logic                   pending;
  logic                   strobe;
  logic                   issue;

  // A push in this cycle with one slot left fills the queue.
  assign issue = run_i && !pending && !full_i && !(push_o && almost_full_i);

  assign bus.cyc   = pending;
  assign bus.stb   = strobe;
  assign bus.we    = 1'b0;
  assign bus.adr   = pc;
  assign bus.dat_w = '0;

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      pc      <= '0;
      pending <= 1'b0;
      strobe  <= 1'b0;
      push_o  <= 1'b0;
    end
    else
    begin
      strobe <= issue;
      push_o <= bus.ack;
      if (issue)
        pending <= 1'b1;
      else if (bus.ack)
      begin
        pending <= 1'b0;
        pc      <= pc + 1'b1;
      end
    end

  always_ff @(posedge clk_i)
    if (bus.ack)
      push_data_o <= bus.dat_r;
endmodule

//--- logic/ins_queue.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module ins_queue (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  logic [`CORE_DAT_W-1:0] push_data_i,
  input  logic                   pop_i,
  output logic [`CORE_DAT_W-1:0] head_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic                   almost_full_o
);
  localparam int DEPTH = `CORE_INSQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [`CORE_DAT_W-1:0] slots [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W:0]         count;

  always_ff @(posedge clk_i)
    if (push_i)
      slots[wr_ptr] <= push_data_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1; // Wraps at the power of two.
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end

  assign head_o        = slots[rd_ptr];
  assign empty_o       = (count == '0);
  assign full_o        = (count == (PTR_W+1)'(DEPTH));
  assign almost_full_o = (count == (PTR_W+1)'(DEPTH - 1)); // One slot left.
endmodule

//--- logic/ram.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module ram (
  input logic  clk_i,
  input logic  arst_n_i,
  wb_bus.slave bus
);
  logic [`CORE_DAT_W-1:0] mem [2**`CORE_ADR_W];
  logic [`CORE_DAT_W-1:0] rd_q;
  logic                   ack_q;

  always_ff @(posedge clk_i)
    if (bus.cyc && bus.stb)
    begin
      if (bus.we)
        mem[bus.adr] <= bus.dat_w;
      rd_q <= mem[bus.adr]; // Old word on a write.
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus.cyc && bus.stb;

  assign bus.dat_r = rd_q;
  assign bus.ack   = ack_q;
endmodule

//--- logic/wb_bus.sv
`timescale 1ns/1ps
`include "core_settings.svh"

interface wb_bus;
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`CORE_ADR_W-1:0] adr;
  logic [`CORE_DAT_W-1:0] dat_w;
  logic [`CORE_DAT_W-1:0] dat_r;
  logic                   ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );
endinterface

//--- project.f
+incdir+include
logic/core_pkg.sv
logic/wb_bus.sv
logic/ifetch.sv
logic/ins_queue.sv
logic/execute.sv
logic/buscontrol.sv
logic/ram.sv
logic/core_top.sv
test/tb_core_top.sv

//--- test/core_tests.txt
# P adr word = program word, D adr word = data preload, S adr value = expected store in order
# A value = expected final accumulator, E = end of test; all numbers in hex
P 000 10000001
P 001 20001111
P 002 20002222
P 003 20003333
P 004 20004444
P 005 20005555
P 006 20006666
P 007 20007777
P 008 20008888
P 009 f0000000
A 00026665
E
D 100 fffffff0
P 000 30000100
P 001 20000025
P 002 f0000000
A 00000015
E
D 180 a5a5a5a5
P 000 1000beef
P 001 40000200
P 002 10000001
P 003 30000200
P 004 20000011
P 005 40000201
P 006 30000180
P 007 40000202
P 008 f0000000
S 200 0000beef
S 201 0000bf00
S 202 a5a5a5a5
A a5a5a5a5
E

//--- test/tb_core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core_top;
  localparam int JUNK_WORDS       = 16;
  localparam int POST_HALT_CYCLES = 24;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   run_i;
  logic                   load_we_i;
  logic [`CORE_ADR_W-1:0] load_adr_i;
  logic [`CORE_DAT_W-1:0] load_dat_i;
  logic [`CORE_DAT_W-1:0] acc_o;
  logic                   st_valid_o;
  logic [`CORE_ADR_W-1:0] st_adr_o;
  logic [`CORE_DAT_W-1:0] st_dat_o;
  logic                   halted_o;

  logic [31:0]            lcg_state = 32'hf737bf37;
  logic [`CORE_ADR_W-1:0] ld_adr [$];
  logic [`CORE_DAT_W-1:0] ld_dat [$];
  logic [`CORE_ADR_W-1:0] exp_adr [$];
  logic [`CORE_DAT_W-1:0] exp_dat [$];
  logic [`CORE_DAT_W-1:0] exp_acc;
  int                     st_idx;
  int                     budget = 0;
  int                     run_cycles;
  int                     prog_words;
  int                     prog_top;

  core_top u_core_top (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic host_write(input logic [`CORE_ADR_W-1:0] adr,
                            input logic [`CORE_DAT_W-1:0] dat);
    @(posedge clk_i);
    load_we_i  <= 1'b1;
    load_adr_i <= adr;
    load_dat_i <= dat;
  endtask

  // Reads one block up to its E line; found stays low at end of file.
  task automatic read_test(input int fd, output bit found);
    logic [7:0]       tag;
    logic [31:0]      a;
    logic [31:0]      w;
    logic [8*120-1:0] rest;
    int               code;
    found = 1'b0;
    ld_adr.delete();
    ld_dat.delete();
    exp_adr.delete();
    exp_dat.delete();
    prog_words = 0;
    prog_top   = 0;
    forever
    begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1)
        return;
      case (tag)
        "#": code = $fgets(rest, fd);
        "P", "D", "S":
        begin
          code = $fscanf(fd, "%h %h", a, w);
          if (tag == "S")
          begin
            exp_adr.push_back(a[`CORE_ADR_W-1:0]);
            exp_dat.push_back(w);
          end
          else
          begin
            ld_adr.push_back(a[`CORE_ADR_W-1:0]);
            ld_dat.push_back(w);
          end
          if (tag == "P")
          begin
            prog_words++;
            if (int'(a) > prog_top)
              prog_top = int'(a);
          end
        end
        "A": code = $fscanf(fd, "%h", exp_acc);
        "E":
        begin
          found = 1'b1;
          return;
        end
        default: abort_run($sformatf("unknown line tag '%c' in tests file", tag));
      endcase
    end
  endtask

  task automatic run_test(input int num);
    logic [3:0] junk_op;
    st_idx = 0;
    @(posedge clk_i);
    arst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int i = 1; i <= JUNK_WORDS; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      junk_op   = 4'd5 + 4'(lcg_state[31:24] % 10); // Opcodes 5 to 14 run as NOP.
      host_write((`CORE_ADR_W)'(prog_top + i), {junk_op, lcg_state[27:0]});
    end
    foreach (ld_adr[i])
      host_write(ld_adr[i], ld_dat[i]);
    @(posedge clk_i);
    load_we_i <= 1'b0;
    @(posedge clk_i);
    budget = 200 * prog_words;
    run_i <= 1'b1;
    while (!halted_o)
      @(negedge clk_i);
    repeat (POST_HALT_CYCLES) // Junk words get fetched here.
    begin
      @(negedge clk_i);
      check_value(halted_o, 1, $sformatf("test %0d halted_o after HALT", num));
    end
    check_value(acc_o, exp_acc, $sformatf("test %0d final accumulator", num));
    if (st_idx != exp_adr.size())
      abort_run($sformatf("test %0d: missing expected store", num));
    @(posedge clk_i);
    run_i <= 1'b0;
  endtask

  always @(negedge clk_i)
    if (st_valid_o)
    begin
      if (st_idx >= exp_adr.size())
        abort_run("store seen after all expected stores");
      else
      begin
        check_value(st_adr_o, exp_adr[st_idx], "store address");
        check_value(st_dat_o, exp_dat[st_idx], "store data");
        st_idx++;
      end
    end

  initial
  begin
    run_cycles = 0;
    forever
    begin
      @(posedge clk_i);
      run_cycles = run_i ? run_cycles + 1 : 0;
      if (run_i && run_cycles > budget)
        abort_run("watchdog timeout: core never halted");
    end
  end

  initial
  begin
    int fd;
    int num;
    bit found;
    arst_n_i   = 1'b0;
    run_i      = 1'b0;
    load_we_i  = 1'b0;
    load_adr_i = '0;
    load_dat_i = '0;
    num        = 0;
    fd = $fopen("test/core_tests.txt", "r");
    if (fd == 0)
      abort_run("cannot open test/core_tests.txt");
    else
    begin
      read_test(fd, found);
      while (found)
      begin
        run_test(num);
        num++;
        read_test(fd, found);
      end
      $fclose(fd);
      if (num == 0)
        abort_run("no tests found in test/core_tests.txt");
      else
      begin
        $display("TEST OK");
        $finish;
      end
    end
  end
endmodule
